//--- common/alu_cfg.svh
// Width defines for the integer ALU: data, command word and immediate field

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width
`define ALU_XLEN 32

// Command word width
// Holds opcode, is_imm and the immediate field
`define ALU_CMD_W 16

// Immediate field width, signed
`define ALU_IMM_W 11

`endif

//--- common/alu_cmd_pkg.sv
// Command package: opcode constants and the register/immediate command union

`include "alu_cfg.svh"

package alu_cmd_pkg;

    // Opcode field width, whatever is left of the word
    localparam int OP_W = `ALU_CMD_W - `ALU_IMM_W - 1;

    // Opcodes, 11 to 15 unused
    localparam logic [OP_W-1:0] OP_ADD  = 4'd0;
    localparam logic [OP_W-1:0] OP_SUB  = 4'd1;
    localparam logic [OP_W-1:0] OP_SLT  = 4'd2;
    localparam logic [OP_W-1:0] OP_SLTU = 4'd3;
    localparam logic [OP_W-1:0] OP_MIN  = 4'd4;
    localparam logic [OP_W-1:0] OP_MAX  = 4'd5;
    localparam logic [OP_W-1:0] OP_MINU = 4'd6;
    localparam logic [OP_W-1:0] OP_MAXU = 4'd7;
    localparam logic [OP_W-1:0] OP_AND  = 4'd8;
    localparam logic [OP_W-1:0] OP_OR   = 4'd9;
    localparam logic [OP_W-1:0] OP_XOR  = 4'd10;

    // One command word, two views
    // is_imm picks which one is meaningful
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]       opcode;
            logic                  is_imm;
            logic [`ALU_IMM_W-1:0] rsvd;
        } reg_form;
        struct packed {
            logic [OP_W-1:0]              opcode;
            logic                         is_imm;
            logic signed [`ALU_IMM_W-1:0] imm;
        } imm_form;
    } alu_cmd_u;

endpackage

//--- common/alu_flag_pkg.sv
// Flag package: flag vector width and the zero, negative, carry, overflow positions

package alu_flag_pkg;

    // Width of the flag vector
    localparam int FLAG_W = 4;

    // Result equals zero
    localparam int FLAG_ZERO = 0;

    // Top bit of the result
    localparam int FLAG_NEG = 1;

    // Unsigned carry out of the adder
    // For SUB and compares, 1 means no borrow
    localparam int FLAG_CARRY = 2;

    // Signed overflow of the adder operation
    localparam int FLAG_OVF = 3;

endpackage

//--- hdl/ks_adder.sv
// Kogge-Stone parallel-prefix adder with sum and carry out, combinational

module ks_adder #(
    parameter int N = 16
) (
    input  logic [N-1:0] dataa,
    input  logic [N-1:0] datab,
    output logic [N-1:0] sum,
    output logic         cout
);

    // Number of prefix levels
    localparam int LEVELS = $clog2(N);

    // Generate and propagate per level, level 0 is bitwise
    logic [N-1:0] gen [LEVELS+1];
    logic [N-1:0] prp [LEVELS+1];

    // Bitwise generate and propagate
    for (genvar i = 0; i < N; i++) begin : g_bit_gp
        assign gen[0][i] = dataa[i] & datab[i];
        assign prp[0][i] = dataa[i] ^ datab[i];
    end

    // Prefix tree, span doubles each level
    for (genvar k = 1; k <= LEVELS; k++) begin : g_level
        localparam int SPAN = 1 << (k - 1);
        for (genvar i = 0; i < N; i++) begin : g_node
            if (i >= SPAN) begin : g_merge
                // Combine with the group SPAN bits below
                assign gen[k][i] = gen[k-1][i] | (prp[k-1][i] & gen[k-1][i-SPAN]);
                assign prp[k][i] = prp[k-1][i] & prp[k-1][i-SPAN];
            end else begin : g_keep
                // Group already reaches bit 0
                assign gen[k][i] = gen[k-1][i];
                assign prp[k][i] = prp[k-1][i];
            end
        end
    end

    // No carry into bit 0
    assign sum[0] = prp[0][0];

    // Carry into bit i is the full prefix generate of bit i-1
    for (genvar i = 1; i < N; i++) begin : g_sum
        assign sum[i] = prp[0][i] ^ gen[LEVELS][i-1];
    end

    // Unsigned carry out of the top bit
    assign cout = gen[LEVELS][N-1];

endmodule

//--- alu/alu_decode.sv
// Stage 1 of the ALU: command decode, operand B select and stage-1 register

`include "alu_cfg.svh"

module alu_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_in,
    input  alu_cmd_pkg::alu_cmd_u    cmd,
    input  logic [`ALU_XLEN-1:0]     rs1,
    input  logic [`ALU_XLEN-1:0]     rs2,
    output logic                     dec_valid,
    output logic [3:0]               dec_op,
    output logic [`ALU_XLEN-1:0]     dec_a,
    output logic [`ALU_XLEN-1:0]     dec_b
);

    // Operand B before the register
    logic [`ALU_XLEN-1:0] opb;

    // Sign-extended immediate
    logic [`ALU_XLEN-1:0] imm_ext;

    // Immediate form, replicate the sign bit up to full width
    assign imm_ext = {{(`ALU_XLEN - `ALU_IMM_W){cmd.imm_form.imm[`ALU_IMM_W-1]}},
                      cmd.imm_form.imm};

    // is_imm selects the view of the word
    always_comb begin
        if (cmd.reg_form.is_imm) begin
            opb = imm_ext;
        end else begin
            opb = rs2;
        end
    end

    // Valid bit of stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= valid_in;
        end
    end

    // Operands and opcode, held while no command arrives
    always_ff @(posedge clk) begin
        if (valid_in) begin
            dec_op <= cmd.reg_form.opcode;
            dec_a  <= rs1;
            dec_b  <= opb;
        end
    end

endmodule

//--- alu/alu_exec.sv
// Stage 2 of the ALU: shared prefix adder, compare, min/max, logic ops, flags, output register

`include "alu_cfg.svh"

module alu_exec (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             dec_valid,
    input  logic [3:0]                       dec_op,
    input  logic [`ALU_XLEN-1:0]             dec_a,
    input  logic [`ALU_XLEN-1:0]             dec_b,
    output logic                             valid_out,
    output logic [`ALU_XLEN-1:0]             result,
    output logic [alu_flag_pkg::FLAG_W-1:0]  flags
);

    // Adder is one bit wider, the extra low bit carries the +1 of SUB
    localparam int AW = `ALU_XLEN + 1;

    logic                 use_sub;
    logic                 arith;
    logic [`ALU_XLEN-1:0] opb;
    logic [AW-1:0]        add_a;
    logic [AW-1:0]        add_b;
    logic [AW-1:0]        add_sum;
    logic                 add_cout;
    logic [`ALU_XLEN-1:0] diff;
    logic                 ovf;
    logic                 lt_s;
    logic                 lt_u;
    logic [`ALU_XLEN-1:0] res_d;
    logic [alu_flag_pkg::FLAG_W-1:0] flags_d;

    // SUB and all compares run a - b
    assign use_sub = (dec_op >= alu_cmd_pkg::OP_SUB) && (dec_op <= alu_cmd_pkg::OP_MAXU);
    // Ops whose carry and overflow flags are meaningful
    assign arith   = (dec_op <= alu_cmd_pkg::OP_MAXU);

    // Invert B for subtraction
    assign opb   = use_sub ? ~dec_b : dec_b;
    // Two low ones generate the carry into bit 1, two zeros add nothing
    assign add_a = {dec_a, use_sub};
    assign add_b = {opb, use_sub};

    ks_adder #(
        .N (AW)
    ) i_adder (
        .dataa (add_a),
        .datab (add_b),
        .sum   (add_sum),
        .cout  (add_cout)
    );

    // Drop the injected carry bit
    assign diff = add_sum[AW-1:1];

    // Same-signed adder inputs, sum of the other sign
    assign ovf  = (dec_a[`ALU_XLEN-1] == opb[`ALU_XLEN-1]) &&
                  (diff[`ALU_XLEN-1] != dec_a[`ALU_XLEN-1]);
    assign lt_s = diff[`ALU_XLEN-1] ^ ovf;
    // Borrow means a < b unsigned
    assign lt_u = ~add_cout;

    // Result select
    always_comb begin
        case (dec_op)
            alu_cmd_pkg::OP_ADD,
            alu_cmd_pkg::OP_SUB:  res_d = diff;
            alu_cmd_pkg::OP_SLT:  res_d = {{(`ALU_XLEN-1){1'b0}}, lt_s};
            alu_cmd_pkg::OP_SLTU: res_d = {{(`ALU_XLEN-1){1'b0}}, lt_u};
            alu_cmd_pkg::OP_MIN:  res_d = lt_s ? dec_a : dec_b;
            alu_cmd_pkg::OP_MAX:  res_d = lt_s ? dec_b : dec_a;
            alu_cmd_pkg::OP_MINU: res_d = lt_u ? dec_a : dec_b;
            alu_cmd_pkg::OP_MAXU: res_d = lt_u ? dec_b : dec_a;
            alu_cmd_pkg::OP_AND:  res_d = dec_a & dec_b;
            alu_cmd_pkg::OP_OR:   res_d = dec_a | dec_b;
            alu_cmd_pkg::OP_XOR:  res_d = dec_a ^ dec_b;
            default:              res_d = '0;
        endcase
    end

    // Flags from the selected result and the adder
    always_comb begin
        flags_d = '0;
        flags_d[alu_flag_pkg::FLAG_ZERO]  = (res_d == '0);
        flags_d[alu_flag_pkg::FLAG_NEG]   = res_d[`ALU_XLEN-1];
        flags_d[alu_flag_pkg::FLAG_CARRY] = arith & add_cout;
        flags_d[alu_flag_pkg::FLAG_OVF]   = arith & ovf;
    end

    // Output register, loads only on a valid stage-1 entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            valid_out <= dec_valid;
            if (dec_valid) begin
                result <= res_d;
                flags  <= flags_d;
            end
        end
    end

endmodule

//--- hdl/int_alu_top.sv
// Top level of the two-stage integer ALU: decode stage feeding execute stage

`include "alu_cfg.svh"

module int_alu_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  alu_cmd_pkg::alu_cmd_u            cmd,
    input  logic [`ALU_XLEN-1:0]             rs1,
    input  logic [`ALU_XLEN-1:0]             rs2,
    output logic                             valid_out,
    output logic [`ALU_XLEN-1:0]             result,
    output logic [alu_flag_pkg::FLAG_W-1:0]  flags
);

    // Stage 1 to stage 2
    logic                 dec_valid;
    logic [3:0]           dec_op;
    logic [`ALU_XLEN-1:0] dec_a;
    logic [`ALU_XLEN-1:0] dec_b;

    alu_decode i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .cmd       (cmd),
        .rs1       (rs1),
        .rs2       (rs2),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b)
    );

    alu_exec i_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .valid_out (valid_out),
        .result    (result),
        .flags     (flags)
    );

endmodule

//--- test/int_alu_assert.sv
// Concurrent assertions on the ALU top level: reset quiet, two-edge latency, zero flag

`include "alu_cfg.svh"

module int_alu_assert (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            valid_in,
    input logic                            valid_out,
    input logic [`ALU_XLEN-1:0]            result,
    input logic [alu_flag_pkg::FLAG_W-1:0] flags
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int fail_cnt = 0;

    // No strobe while reset is held
    a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !valid_out)
        else begin
            fail_cnt++;
            $error("valid_out high during reset");
        end

    // Each accepted input shows up exactly two edges later
    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
                                 valid_out == $past(valid_in, 2))
        else begin
            fail_cnt++;
            $error("valid_out does not follow valid_in by two edges");
        end

    // Zero flag tracks a zero result
    a_zero_flag : assert property (@(posedge clk) disable iff (!rst_n)
                                   valid_out |-> flags[alu_flag_pkg::FLAG_ZERO] == (result == '0))
        else begin
            fail_cnt++;
            $error("zero flag disagrees with result");
        end

endmodule

bind int_alu_top int_alu_assert i_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .result    (result),
    .flags     (flags)
);

//--- test/int_alu_checker.sv
// ALU checker with reference model, expectation queue, output compare and per-test lines

`include "alu_cfg.svh"

module int_alu_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            valid_in,
    input  alu_cmd_pkg::alu_cmd_u           cmd,
    input  logic [`ALU_XLEN-1:0]            rs1,
    input  logic [`ALU_XLEN-1:0]            rs2,
    input  logic                            valid_out,
    input  logic [`ALU_XLEN-1:0]            result,
    input  logic [alu_flag_pkg::FLAG_W-1:0] flags,
    output int                              pending,
    output int                              pass_cnt,
    output int                              err_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int X = `ALU_XLEN;

    // Expected values in issue order
    logic [X-1:0] q_res [$];
    logic [3:0]   q_flg [$];
    logic [3:0]   q_op [$];
    int           q_cyc [$];
    int           q_tag [$];
    int           cyc;
    int           tests;

    // Model from the ALU rules
    // The wide sum holds the carry in bit X
    task automatic predict(input logic [3:0] op, input logic [X-1:0] a,
                           input logic [X-1:0] b, output logic [X-1:0] res,
                           output logic [3:0] flg);
        logic [X:0]   wide;
        logic [X-1:0] bb;
        logic         arith;
        logic         sub;
        logic         lt_s;
        logic         lt_u;
        arith = (op <= alu_cmd_pkg::OP_MAXU);
        sub   = arith && (op != alu_cmd_pkg::OP_ADD);
        bb    = sub ? ~b : b;
        wide  = {1'b0, a} + {1'b0, bb} + sub;
        lt_s  = $signed(a) < $signed(b);
        lt_u  = a < b;
        case (op)
            alu_cmd_pkg::OP_ADD,
            alu_cmd_pkg::OP_SUB:  res = wide[X-1:0];
            alu_cmd_pkg::OP_SLT:  res = lt_s;
            alu_cmd_pkg::OP_SLTU: res = lt_u;
            alu_cmd_pkg::OP_MIN:  res = lt_s ? a : b;
            alu_cmd_pkg::OP_MAX:  res = lt_s ? b : a;
            alu_cmd_pkg::OP_MINU: res = lt_u ? a : b;
            alu_cmd_pkg::OP_MAXU: res = lt_u ? b : a;
            alu_cmd_pkg::OP_AND:  res = a & b;
            alu_cmd_pkg::OP_OR:   res = a | b;
            alu_cmd_pkg::OP_XOR:  res = a ^ b;
            default:              res = '0;
        endcase
        flg = '0;
        flg[alu_flag_pkg::FLAG_ZERO]  = (res == '0);
        flg[alu_flag_pkg::FLAG_NEG]   = res[X-1];
        flg[alu_flag_pkg::FLAG_CARRY] = arith & wide[X];
        // Equal-signed adder inputs giving the other sign
        flg[alu_flag_pkg::FLAG_OVF]   = arith & (a[X-1] == bb[X-1]) & (wide[X-1] != a[X-1]);
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin : p_watch
        logic [X-1:0] b;
        logic [X-1:0] e_res;
        logic [3:0]   e_flg;
        logic [3:0]   e_op;
        int           e_cyc;
        int           tag;
        logic         ok;
        cyc++;
        // Outputs sit at their reset values while rst_n is low
        if (!rst_n) begin
            if (valid_out !== 1'b0) begin
                $display("Error at %0t ns: valid_out expected 0 actual %b during reset",
                         $time, valid_out);
                err_cnt++;
            end
            if (result !== '0) begin
                $display("Error at %0t ns: result expected %h actual %h during reset",
                         $time, {X{1'b0}}, result);
                err_cnt++;
            end
            if (flags !== '0) begin
                $display("Error at %0t ns: flags expected %b actual %b during reset",
                         $time, 4'b0000, flags);
                err_cnt++;
            end
        end
        if (rst_n && valid_out) begin
            if (q_res.size() == 0) begin
                $display("Error at %0t ns: valid_out strobe with no operation in flight", $time);
                err_cnt++;
            end else begin
                e_res = q_res.pop_front();
                e_flg = q_flg.pop_front();
                e_op  = q_op.pop_front();
                e_cyc = q_cyc.pop_front();
                tag   = q_tag.pop_front();
                ok    = 1'b1;
                if (cyc != e_cyc + 2) begin
                    $display("Error at %0t ns: test %0d came out at cycle %0d, not cycle %0d",
                             $time, tag, cyc, e_cyc + 2);
                    ok = 1'b0;
                end
                if (result !== e_res) begin
                    $display("Error at %0t ns: result expected %h actual %h",
                             $time, e_res, result);
                    ok = 1'b0;
                end
                if (flags !== e_flg) begin
                    $display("Error at %0t ns: flags expected %b actual %b",
                             $time, e_flg, flags);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_cnt++;
                    $display("test %0d op %0d ok, result %h flags %b", tag, e_op, result, flags);
                end else begin
                    err_cnt++;
                    $display("test %0d op %0d failed", tag, e_op);
                end
            end
        end
        // Accepted operation takes B from the view that is_imm names
        if (rst_n && valid_in) begin
            if (cmd.reg_form.is_imm) begin
                b = X'($signed(cmd.imm_form.imm));
            end else begin
                b = rs2;
            end
            predict(cmd.reg_form.opcode, rs1, b, e_res, e_flg);
            q_res.push_back(e_res);
            q_flg.push_back(e_flg);
            q_op.push_back(cmd.reg_form.opcode);
            q_cyc.push_back(cyc);
            q_tag.push_back(tests);
            tests++;
        end
        pending = q_res.size();
    end

endmodule

//--- test/int_alu_tb.sv
// Testbench top for the integer ALU: clock, reset, stimulus table, random rows, summary

`include "alu_cfg.svh"

module int_alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                            clk;
    logic                            rst_n;
    logic                            valid_in;
    alu_cmd_pkg::alu_cmd_u           cmd;
    logic [`ALU_XLEN-1:0]            rs1;
    logic [`ALU_XLEN-1:0]            rs2;
    logic                            valid_out;
    logic [`ALU_XLEN-1:0]            result;
    logic [alu_flag_pkg::FLAG_W-1:0] flags;

    // Stimulus table, one row per operation, gap is idle cycles before the row
    alu_cmd_pkg::alu_cmd_u tab_cmd [$];
    logic [`ALU_XLEN-1:0]  tab_a [$];
    logic [`ALU_XLEN-1:0]  tab_b [$];
    int                    tab_gap [$];

    int                    pending;
    int                    pass_cnt;
    int                    err_cnt;
    int                    waited;
    integer                seed;
    logic [31:0]           rnd_cmd;
    logic [31:0]           rnd_a;
    logic [31:0]           rnd_b;
    logic [31:0]           rnd_gap;

    int_alu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .cmd       (cmd),
        .rs1       (rs1),
        .rs2       (rs2),
        .valid_out (valid_out),
        .result    (result),
        .flags     (flags)
    );

    // Watches the DUT pins directly
    int_alu_checker i_check (
        .clk       (i_dut.clk),
        .rst_n     (i_dut.rst_n),
        .valid_in  (i_dut.valid_in),
        .cmd       (i_dut.cmd),
        .rs1       (i_dut.rs1),
        .rs2       (i_dut.rs2),
        .valid_out (i_dut.valid_out),
        .result    (i_dut.result),
        .flags     (i_dut.flags),
        .pending   (pending),
        .pass_cnt  (pass_cnt),
        .err_cnt   (err_cnt)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // Register form puts iv into the reserved bits as junk
    task automatic add_row(input logic [3:0] op, input logic imm, input logic [10:0] iv,
                           input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b,
                           input int gap);
        alu_cmd_pkg::alu_cmd_u c;
        c = '0;
        if (imm) begin
            c.imm_form.opcode = op;
            c.imm_form.is_imm = 1'b1;
            c.imm_form.imm    = iv;
        end else begin
            c.reg_form.opcode = op;
            c.reg_form.is_imm = 1'b0;
            c.reg_form.rsvd   = iv;
        end
        tab_cmd.push_back(c);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_gap.push_back(gap);
    endtask

    task automatic build_table();
        // Add and subtract corners, max plus one, min minus one, 0 minus 0
        add_row(alu_cmd_pkg::OP_ADD, 0, 11'h0, 32'd5, 32'd7, 0);
        add_row(alu_cmd_pkg::OP_ADD, 0, 11'h7ff, 32'h7fff_ffff, 32'd1, 0);
        add_row(alu_cmd_pkg::OP_ADD, 0, 11'h0, 32'hffff_ffff, 32'd1, 0);
        add_row(alu_cmd_pkg::OP_SUB, 0, 11'h0, 32'h8000_0000, 32'd1, 0);
        add_row(alu_cmd_pkg::OP_SUB, 0, 11'h0, 32'd0, 32'd0, 2);
        add_row(alu_cmd_pkg::OP_SUB, 0, 11'h0, 32'd3, 32'd5, 0);
        // Immediate form, rs2 holds junk
        add_row(alu_cmd_pkg::OP_ADD, 1, 11'h7ff, 32'd10, 32'hdead_beef, 0);
        add_row(alu_cmd_pkg::OP_ADD, 1, 11'h3ff, 32'd1, 32'h1234_5678, 1);
        add_row(alu_cmd_pkg::OP_SUB, 1, 11'h400, 32'd0, 32'hffff_ffff, 0);
        add_row(alu_cmd_pkg::OP_SLT, 1, 11'h7ff, 32'd0, 32'd0, 0);
        // Orders that disagree across the sign boundary
        add_row(alu_cmd_pkg::OP_SLT, 0, 11'h0, 32'hffff_ffff, 32'd1, 0);
        add_row(alu_cmd_pkg::OP_SLTU, 0, 11'h0, 32'hffff_ffff, 32'd1, 0);
        add_row(alu_cmd_pkg::OP_MIN, 0, 11'h0, 32'h8000_0000, 32'h7fff_ffff, 0);
        add_row(alu_cmd_pkg::OP_MAX, 0, 11'h0, 32'h8000_0000, 32'h7fff_ffff, 0);
        add_row(alu_cmd_pkg::OP_MINU, 0, 11'h0, 32'h8000_0000, 32'h7fff_ffff, 0);
        add_row(alu_cmd_pkg::OP_MAXU, 0, 11'h0, 32'h8000_0000, 32'h7fff_ffff, 3);
        add_row(alu_cmd_pkg::OP_SLT, 0, 11'h0, 32'd9, 32'd9, 0);
        // Logic ops, then unused opcodes
        add_row(alu_cmd_pkg::OP_AND, 0, 11'h0, 32'hf0f0_ff00, 32'hff00_f0f0, 0);
        add_row(alu_cmd_pkg::OP_OR, 0, 11'h0, 32'hf0f0_ff00, 32'h0f0f_000f, 0);
        add_row(alu_cmd_pkg::OP_XOR, 0, 11'h0, 32'h5a5a_5a5a, 32'h5a5a_5a5a, 1);
        add_row(4'd11, 0, 11'h0, 32'h1111_1111, 32'h2222_2222, 0);
        add_row(4'd15, 1, 11'h123, 32'hffff_ffff, 32'hffff_ffff, 0);
        // Random rows, an idle cycle now and then
        for (int i = 0; i < 40; i++) begin
            rnd_cmd = $random(seed);
            rnd_a   = $random(seed);
            rnd_b   = $random(seed);
            rnd_gap = $random(seed);
            add_row(rnd_cmd[3:0], rnd_cmd[4], rnd_cmd[15:5], rnd_a, rnd_b,
                    (rnd_gap[2:0] == 3'd0) ? 1 : 0);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b1;
        valid_in = 1'b0;
        cmd      = '0;
        rs1      = '0;
        rs2      = '0;
        seed     = 81404;
        build_table();
        // Clean falling reset edge just after time zero
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        // One row per cycle, inputs change 1 ns after the edge
        for (int i = 0; i < tab_cmd.size(); i++) begin
            repeat (tab_gap[i]) begin
                valid_in = 1'b0;
                @(posedge clk);
                #1;
            end
            valid_in = 1'b1;
            cmd      = tab_cmd[i];
            rs1      = tab_a[i];
            rs2      = tab_b[i];
            @(posedge clk);
            #1;
        end
        valid_in = 1'b0;
        // Drain the pipe, 50 cycles at most
        waited = 0;
        while (pending != 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        // Quiet cycles so a stray strobe still shows up
        repeat (4) @(posedge clk);
        if (pending != 0) begin
            $display("Timeout: %0d results missing after 50 cycles", pending);
        end
        $display("Done: %0d passed, %0d errors, %0d assertion failures",
                 pass_cnt, err_cnt, i_dut.i_assert.fail_cnt);
        if (pending != 0 || err_cnt != 0 || i_dut.i_assert.fail_cnt != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

//--- int_alu.f
+incdir+common
common/alu_cmd_pkg.sv
common/alu_flag_pkg.sv
hdl/ks_adder.sv
alu/alu_decode.sv
alu/alu_exec.sv
hdl/int_alu_top.sv
test/int_alu_assert.sv
test/int_alu_checker.sv
test/int_alu_tb.sv

//--- Bender.yml
package:
  name: int_alu

sources:
  # ALU design
  - include_dirs:
      - common
    files:
      - common/alu_cmd_pkg.sv
      - common/alu_flag_pkg.sv
      - hdl/ks_adder.sv
      - alu/alu_decode.sv
      - alu/alu_exec.sv
      - hdl/int_alu_top.sv
  # Testbench, top module int_alu_tb
  - target: test
    include_dirs:
      - common
    files:
      - test/int_alu_assert.sv
      - test/int_alu_checker.sv
      - test/int_alu_tb.sv
